// File: branch_pkg.sv
package branch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // predictor sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int LHT_DEPTH = 8;
  localparam int LHT_IX_W  = $clog2(LHT_DEPTH);
  localparam int LHIST_W   = 2;
  localparam int LP_DEPTH  = 2 ** LHIST_W;
  localparam int GHIST_W   = 3;
  localparam int GAC_DEPTH = 2 ** GHIST_W;

  ////////////////////////////////////////////////////////////////////////////
  // rv32i encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // both views share the opcode in bits [6:0].
  typedef union packed {
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [1:0] {
    KIND_NONE = 2'd0,
    KIND_COND = 2'd1,
    KIND_JAL  = 2'd2
  } branch_kind_e;

  ////////////////////////////////////////////////////////////////////////////
  // stage records
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                taken;
    logic                local_taken;
    logic                global_taken;
    logic [LHT_IX_W-1:0] lht_ix;
    logic [LHIST_W-1:0]  lhist;
    logic [GHIST_W-1:0]  ghist;
  } pred_info_t;

  typedef struct packed {
    logic         valid;
    branch_kind_e kind;
    logic [2:0]   funct3;
    logic [31:0]  pc;
    logic [31:0]  target;
    logic [31:0]  rs1;
    logic [31:0]  rs2;
    pred_info_t   pred;
  } decoded_t;

  typedef struct packed {
    logic         valid;
    branch_kind_e kind;
    logic [31:0]  pc;
    logic [31:0]  target;
    logic [31:0]  fall_pc;
    logic         actual_taken;
    pred_info_t   pred;
  } executed_t;

  typedef struct packed {
    logic       valid;
    logic       actual_taken;
    pred_info_t pred;
  } train_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        taken;
    logic        mispredict;
    logic [31:0] next_pc;
  } branch_result_t;

endpackage

// File: branch_decode.sv
`timescale 1ns/10ps
module branch_decode (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    instr_valid,
  input  branch_pkg::instr_u      instr,
  input  logic [31:0]             pc,
  input  logic [31:0]             rs1_data,
  input  logic [31:0]             rs2_data,
  output logic [31:0]             lookup_pc,
  input  branch_pkg::pred_info_t  pred,
  output branch_pkg::decoded_t    decoded
);

  branch_pkg::branch_kind_e kind;
  logic [31:0]              b_imm;
  logic [31:0]              j_imm;
  logic [31:0]              imm;

  // the predictor is looked up in the same cycle the instruction arrives.
  assign lookup_pc = pc;

  assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

  always_comb begin
    kind = branch_pkg::KIND_NONE;
    imm  = b_imm;
    case (instr.b.opcode)
      branch_pkg::OP_BRANCH: begin
        // funct3 values 010 and 011 are not branches.
        case (instr.b.funct3)
          branch_pkg::F3_BEQ, branch_pkg::F3_BNE, branch_pkg::F3_BLT,
          branch_pkg::F3_BGE, branch_pkg::F3_BLTU, branch_pkg::F3_BGEU: begin
            kind = branch_pkg::KIND_COND;
          end
          default: kind = branch_pkg::KIND_NONE;
        endcase
      end
      branch_pkg::OP_JAL: begin
        kind = branch_pkg::KIND_JAL;
        imm  = j_imm;
      end
      default: kind = branch_pkg::KIND_NONE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid  <= instr_valid && (kind != branch_pkg::KIND_NONE);
      decoded.kind   <= kind;
      decoded.funct3 <= instr.b.funct3;
      decoded.pc     <= pc;
      decoded.target <= pc + imm;
      decoded.rs1    <= rs1_data;
      decoded.rs2    <= rs2_data;
      decoded.pred   <= pred;
      // jal is unconditional.
      if (kind == branch_pkg::KIND_JAL) begin
        decoded.pred.taken <= 1'b1;
      end
    end
  end

endmodule

// File: tournament_predictor.sv
`timescale 1ns/10ps
module tournament_predictor (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic [31:0]             lookup_pc,
  output branch_pkg::pred_info_t  pred,
  input  branch_pkg::train_t      train
);

  logic [branch_pkg::LHIST_W-1:0] local_hist_table [branch_pkg::LHT_DEPTH];
  logic [1:0]                     local_ctr [branch_pkg::LP_DEPTH];
  logic [1:0]                     global_ctr [branch_pkg::GAC_DEPTH];
  logic [1:0]                     choice_ctr [branch_pkg::GAC_DEPTH];
  logic [branch_pkg::GHIST_W-1:0] global_hist;

  logic [branch_pkg::LHT_IX_W-1:0] lht_ix;
  logic [branch_pkg::LHIST_W-1:0]  lhist;
  logic                            local_taken;
  logic                            global_taken;

  // two-bit saturating counter step.
  function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic up);
    logic [1:0] next;
    next = ctr;
    if (up && ctr != 2'b11) begin
      next = ctr + 2'b01;
    end else if (!up && ctr != 2'b00) begin
      next = ctr - 2'b01;
    end
    return next;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lht_ix       = lookup_pc[2 +: branch_pkg::LHT_IX_W];
    lhist        = local_hist_table[lht_ix];
    local_taken  = local_ctr[lhist][1];
    global_taken = global_ctr[global_hist][1];

    pred.lht_ix       = lht_ix;
    pred.lhist        = lhist;
    pred.ghist        = global_hist;
    pred.local_taken  = local_taken;
    pred.global_taken = global_taken;
    // the chooser's top bit selects the global component.
    pred.taken        = choice_ctr[global_hist][1] ? global_taken : local_taken;
  end

  ////////////////////////////////////////////////////////////////////////////
  // training
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < branch_pkg::LHT_DEPTH; i++) begin
        local_hist_table[i] <= '0;
      end
      for (int i = 0; i < branch_pkg::LP_DEPTH; i++) begin
        local_ctr[i] <= 2'b00;
      end
      for (int i = 0; i < branch_pkg::GAC_DEPTH; i++) begin
        global_ctr[i] <= 2'b00;
        choice_ctr[i] <= 2'b00;
      end
      global_hist <= '0;
    end else if (train.valid) begin
      // the update writes the entries that were read at prediction time.
      local_ctr[train.pred.lhist] <=
        sat_step(local_ctr[train.pred.lhist], train.actual_taken);
      global_ctr[train.pred.ghist] <=
        sat_step(global_ctr[train.pred.ghist], train.actual_taken);

      // Only a disagreement tells the chooser anything.
      if (train.pred.local_taken != train.pred.global_taken) begin
        choice_ctr[train.pred.ghist] <= sat_step(choice_ctr[train.pred.ghist],
          train.pred.global_taken == train.actual_taken);
      end

      local_hist_table[train.pred.lht_ix] <=
        {train.pred.lhist[branch_pkg::LHIST_W-2:0], train.actual_taken};
      global_hist <= {global_hist[branch_pkg::GHIST_W-2:0], train.actual_taken};
    end
  end

endmodule

// File: branch_execute.sv
`timescale 1ns/10ps
module branch_execute (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  branch_pkg::decoded_t  decoded,
  output branch_pkg::executed_t executed
);

  logic compare_taken;
  logic actual_taken;

  always_comb begin
    case (decoded.funct3)
      branch_pkg::F3_BEQ:  compare_taken = decoded.rs1 == decoded.rs2;
      branch_pkg::F3_BNE:  compare_taken = decoded.rs1 != decoded.rs2;
      branch_pkg::F3_BLT:  compare_taken = $signed(decoded.rs1) < $signed(decoded.rs2);
      branch_pkg::F3_BGE:  compare_taken = $signed(decoded.rs1) >= $signed(decoded.rs2);
      branch_pkg::F3_BLTU: compare_taken = decoded.rs1 < decoded.rs2;
      branch_pkg::F3_BGEU: compare_taken = decoded.rs1 >= decoded.rs2;
      default:             compare_taken = 1'b0;
    endcase
  end

  // jal ignores the compare; its funct3 bits belong to the immediate.
  assign actual_taken = (decoded.kind == branch_pkg::KIND_JAL) ? 1'b1 : compare_taken;

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      executed.valid <= 1'b0;
    end else begin
      executed.valid        <= decoded.valid;
      executed.kind         <= decoded.kind;
      executed.pc           <= decoded.pc;
      executed.target       <= decoded.target;
      executed.fall_pc      <= decoded.pc + 32'd4;
      executed.actual_taken <= actual_taken;
      executed.pred         <= decoded.pred;
    end
  end

endmodule

// File: branch_resolve.sv
`timescale 1ns/10ps
module branch_resolve (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  branch_pkg::executed_t       executed,
  output branch_pkg::branch_result_t  result,
  output branch_pkg::train_t          train
);

  logic        is_cond;
  logic        mispredict;
  logic [31:0] next_pc;

  assign is_cond    = executed.kind == branch_pkg::KIND_COND;
  // jal is never counted as mispredicted.
  assign mispredict = is_cond && (executed.pred.taken != executed.actual_taken);
  assign next_pc    = executed.actual_taken ? executed.target : executed.fall_pc;

  ////////////////////////////////////////////////////////////////////////////
  // result and training record
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      result <= '0;
    end else begin
      result.valid <= executed.valid;
      // Fields keep the last branch between pulses.
      if (executed.valid) begin
        result.pc         <= executed.pc;
        result.taken      <= executed.actual_taken;
        result.mispredict <= mispredict;
        result.next_pc    <= next_pc;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      train.valid <= 1'b0;
    end else begin
      train.valid        <= executed.valid && is_cond;
      train.actual_taken <= executed.actual_taken;
      train.pred         <= executed.pred;
    end
  end

endmodule

// File: branch_unit_top.sv
`timescale 1ns/10ps
module branch_unit_top (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        instr_valid,
  input  logic [31:0]                 instr,
  input  logic [31:0]                 pc,
  input  logic [31:0]                 rs1_data,
  input  logic [31:0]                 rs2_data,
  output branch_pkg::branch_result_t  result
);

  logic [31:0]            lookup_pc;
  branch_pkg::pred_info_t pred;
  branch_pkg::decoded_t   decoded;
  branch_pkg::executed_t  executed;
  branch_pkg::train_t     train;

  branch_decode i_branch_decode (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .lookup_pc   (lookup_pc),
    .pred        (pred),
    .decoded     (decoded)
  );

  tournament_predictor i_tournament_predictor (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .lookup_pc (lookup_pc),
    .pred      (pred),
    .train     (train)
  );

  branch_execute i_branch_execute (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .decoded  (decoded),
    .executed (executed)
  );

  branch_resolve i_branch_resolve (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .executed (executed),
    .result   (result),
    .train    (train)
  );

endmodule

// File: branch_unit_tb.sv
`timescale 1ns/10ps
module branch_unit_tb;

  localparam int          RESET_CYCLES = 8;
  localparam int          N_CYCLES     = 600;
  localparam int          TIMEOUT_NS   = (RESET_CYCLES + N_CYCLES + 3) * 10 + 1000;
  localparam logic [31:0] PC_BASE      = 32'h0001_0000;

  // one expected result, plus the prediction snapshot used to train the model.
  typedef struct packed {
    logic        valid;
    logic        cond;
    logic        first;
    logic [31:0] pc;
    logic        taken;
    logic        mispredict;
    logic [31:0] next_pc;
    logic        local_taken;
    logic        global_taken;
    logic [2:0]  lht_ix;
    logic [1:0]  lhist;
    logic [2:0]  ghist;
  } expect_t;

  logic                       clk_in = 1'b0;
  logic                       rst_in;
  logic                       instr_valid;
  logic [31:0]                instr;
  logic [31:0]                pc;
  logic [31:0]                rs1_data;
  logic [31:0]                rs2_data;
  branch_pkg::branch_result_t result;

  logic [31:0] seed;
  int          errors;
  int          checks;
  logic        first_seen;
  expect_t     pipe [3];

  // reference predictor state.
  logic [1:0]  m_lht [8];
  logic [1:0]  m_lctr [4];
  logic [1:0]  m_gctr [8];
  logic [1:0]  m_cctr [8];
  logic [2:0]  m_ghist;

  branch_unit_top i_branch_unit_top (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .result      (result)
  );

  always #5 clk_in = ~clk_in;

  function automatic logic [15:0] rand16();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];
  endfunction

  function automatic logic [31:0] edge_value(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h0000_0001;
      3'd2:    return 32'h7fff_ffff;
      3'd3:    return 32'h8000_0000;
      3'd4:    return 32'hffff_ffff;
      default: return 32'h8000_0001;
    endcase
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [15:0] r;
    r = rand16();
    case (r[1:0])
      2'd0:    return {{28{r[5]}}, r[5:2]};
      2'd1:    return edge_value(r[4:2]);
      default: return {rand16(), r};
    endcase
  endfunction

  // signed order is unsigned order with the sign bits flipped.
  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [31:0] sa;
    logic [31:0] sb;
    sa = a ^ 32'h8000_0000;
    sb = b ^ 32'h8000_0000;
    case (f3)
      branch_pkg::F3_BEQ:  return a == b;
      branch_pkg::F3_BNE:  return a != b;
      branch_pkg::F3_BLT:  return sa < sb;
      branch_pkg::F3_BGE:  return !(sa < sb);
      branch_pkg::F3_BLTU: return a < b;
      default:             return !(a < b);
    endcase
  endfunction

  function automatic logic [1:0] sat_move(input logic [1:0] ctr, input logic up);
    if (up) begin
      return (ctr == 2'd3) ? ctr : ctr + 2'd1;
    end
    return (ctr == 2'd0) ? ctr : ctr - 2'd1;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic train_model(input expect_t rec);
    m_lctr[rec.lhist] = sat_move(m_lctr[rec.lhist], rec.taken);
    m_gctr[rec.ghist] = sat_move(m_gctr[rec.ghist], rec.taken);
    if (rec.local_taken != rec.global_taken) begin
      m_cctr[rec.ghist] = sat_move(m_cctr[rec.ghist], rec.global_taken == rec.taken);
    end
    m_lht[rec.lht_ix] = {rec.lhist[0], rec.taken};
    m_ghist           = {m_ghist[1:0], rec.taken};
  endtask

  //////////////////////////////////////////////////////////////////////////
  // one falling edge: check, drive, look up, then train
  //////////////////////////////////////////////////////////////////////////

  task automatic step_cycle(input logic allow_valid);
    expect_t     old_rec;
    expect_t     new_rec;
    logic [15:0] r;
    logic        strobe;
    logic [2:0]  sel;
    logic [2:0]  f3;
    logic [12:0] bimm;
    logic [20:0] jimm;
    logic [31:0] pc_w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] word;
    logic [31:0] target;
    logic        pred_taken;

    // the instruction driven three edges ago resolved on the last rising edge.
    old_rec = pipe[2];
    check_value(result.valid, old_rec.valid, "result.valid");
    if (old_rec.valid) begin
      check_value(result.pc, old_rec.pc, "result.pc");
      check_value(result.taken, old_rec.taken, "result.taken");
      check_value(result.mispredict, old_rec.mispredict, "result.mispredict");
      check_value(result.next_pc, old_rec.next_pc, "result.next_pc");
      if (old_rec.first) begin
        check_value(result.mispredict, old_rec.taken, "first branch not predicted not-taken");
      end
    end

    r      = rand16();
    strobe = allow_valid && (r % 10 < 8);
    sel    = r[10:8];
    case (r[15:11] % 6)
      0:       f3 = branch_pkg::F3_BEQ;
      1:       f3 = branch_pkg::F3_BNE;
      2:       f3 = branch_pkg::F3_BLT;
      3:       f3 = branch_pkg::F3_BGE;
      4:       f3 = branch_pkg::F3_BLTU;
      default: f3 = branch_pkg::F3_BGEU;
    endcase
    r    = rand16();
    pc_w = PC_BASE + {26'd0, r[3:0], 2'b00};
    bimm = {r[15:4], 1'b0};
    r    = rand16();
    jimm = {r, bimm[4:1], 1'b0};
    a    = pick_operand();
    b    = (rand16() % 4 == 0) ? a : pick_operand();

    new_rec              = '0;
    new_rec.pc           = pc_w;
    new_rec.lht_ix       = pc_w[4:2];
    new_rec.lhist        = m_lht[pc_w[4:2]];
    new_rec.ghist        = m_ghist;
    new_rec.local_taken  = m_lctr[new_rec.lhist][1];
    new_rec.global_taken = m_gctr[m_ghist][1];
    pred_taken = m_cctr[m_ghist][1] ? new_rec.global_taken : new_rec.local_taken;

    if (sel < 3'd5) begin
      word = {bimm[12], bimm[10:5], 5'd2, 5'd1, f3, bimm[4:1], bimm[11],
              branch_pkg::OP_BRANCH};
      target             = pc_w + {{19{bimm[12]}}, bimm};
      new_rec.cond       = 1'b1;
      new_rec.taken      = branch_taken(f3, a, b);
      new_rec.mispredict = pred_taken != new_rec.taken;
    end else if (sel == 3'd5) begin
      word          = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd1, branch_pkg::OP_JAL};
      target        = pc_w + {{11{jimm[20]}}, jimm};
      new_rec.taken = 1'b1;
    end else begin
      // an alu op or a jalr, neither of which is handled here.
      word   = {a[24:0], (sel == 3'd6) ? 7'b0110011 : 7'b1100111};
      target = 32'd0;
    end
    new_rec.valid   = strobe && (sel <= 3'd5);
    new_rec.next_pc = new_rec.taken ? target : pc_w + 32'd4;
    if (new_rec.valid && new_rec.cond && !first_seen) begin
      new_rec.first = 1'b1;
      first_seen    = 1'b1;
    end

    instr_valid = strobe;
    instr       = word;
    pc          = pc_w;
    rs1_data    = a;
    rs2_data    = b;

    if (old_rec.valid && old_rec.cond) begin
      train_model(old_rec);
    end
    pipe[2] = pipe[1];
    pipe[1] = pipe[0];
    pipe[0] = new_rec;
  endtask

  initial begin
    seed        = 32'd73;
    errors      = 0;
    checks      = 0;
    first_seen  = 1'b0;
    rst_in      = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'd0;
    pc          = 32'd0;
    rs1_data    = 32'd0;
    rs2_data    = 32'd0;
    m_ghist     = 3'd0;
    for (int i = 0; i < 8; i++) begin
      m_lht[i]  = 2'd0;
      m_gctr[i] = 2'd0;
      m_cctr[i] = 2'd0;
    end
    for (int i = 0; i < 4; i++) begin
      m_lctr[i] = 2'd0;
    end
    for (int i = 0; i < 3; i++) begin
      pipe[i] = '0;
    end

    repeat (RESET_CYCLES) @(negedge clk_in);
    rst_in = 1'b0;
    // the last three cycles drain the pipeline.
    for (int n = 0; n < N_CYCLES + 3; n++) begin
      step_cycle(n < N_CYCLES);
      @(negedge clk_in);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: build.f
branch_pkg.sv
branch_decode.sv
tournament_predictor.sv
branch_execute.sv
branch_resolve.sv
branch_unit_top.sv
branch_unit_tb.sv

// File: Makefile
TOP = branch_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
